// File: source/sa_macros.svh
`ifndef SA_MACROS_SVH
`define SA_MACROS_SVH

// Array dimension, also the depth of each lane FIFO.
`define SA_PE_SIZE 4

// Weight and activation width.
`define SA_DATA_W 8

// Partial sum and result width, sized so a full column sum cannot overflow.
`define SA_ACC_W 20

`endif

// File: source/sa_pkg.sv
`include "sa_macros.svh"

package sa_pkg;

    // Weights and activations.
    typedef logic signed [`SA_DATA_W-1:0] data_t;

    // Partial sums and results.
    typedef logic signed [`SA_ACC_W-1:0] acc_t;

    // Weight load sequencer.
    typedef enum logic [1:0] {
        IDLE,
        POP,
        DRAIN
    } load_state_e;

endpackage

// File: source/buf_ctrl_if.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

interface buf_ctrl_if;

    logic                   rden;
    logic                   any_empty;
    logic                   any_full;
    logic [`SA_PE_SIZE-1:0] col_en;

    modport ctrl (
        output rden,
        input  any_empty,
        input  any_full,
        input  col_en
    );

    // Weight buffer side.
    modport wbuf (
        input  rden,
        output any_empty,
        output any_full,
        output col_en
    );

endinterface

// File: source/lane_fifo.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

module lane_fifo (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          wr_en_i,
    input  logic          rd_en_i,
    input  sa_pkg::data_t wr_data_i,
    output sa_pkg::data_t rd_data_o,
    output logic          full_o,
    output logic          empty_o
);

    localparam int DEPTH = `SA_PE_SIZE;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    sa_pkg::data_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Head entry falls through, valid in the same cycle as the pop.
    assign rd_data_o = mem[rd_ptr];
    assign full_o    = (count == (PTR_W + 1)'(DEPTH));
    assign empty_o   = (count == '0);

endmodule

// File: source/weight_buffer.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

module weight_buffer (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            wr_en_i,
    input  sa_pkg::data_t [`SA_PE_SIZE-1:0] wr_data_i,
    output sa_pkg::data_t [`SA_PE_SIZE-1:0] rd_data_o,
    output logic                            buf_full_o,
    buf_ctrl_if.wbuf                        bus
);

    localparam int N = `SA_PE_SIZE;

    logic [N-1:0] pop;
    logic [N-2:0] rden_dly;
    logic [N-1:0] full;
    logic [N-1:0] empty;

    // Lane c pops c cycles after lane 0.
    assign pop = {rden_dly, bus.rden};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rden_dly <= '0;
        end else begin
            rden_dly <= pop[N-2:0];
        end
    end

    for (genvar c = 0; c < N; c++) begin : g_lane
        lane_fifo i_lane_fifo (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .wr_en_i   (wr_en_i),
            .rd_en_i   (pop[c]),
            .wr_data_i (wr_data_i[c]),
            .rd_data_o (rd_data_o[c]),
            .full_o    (full[c]),
            .empty_o   (empty[c])
        );
    end

    // The pop strobes double as the column load enables.
    assign bus.col_en    = pop;
    assign bus.any_empty = |empty;
    assign bus.any_full  = |full;
    assign buf_full_o    = |full;

endmodule

// File: source/sa_ctrl.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

module sa_ctrl (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     load_start_i,
    input  logic     act_valid_i,
    buf_ctrl_if.ctrl bus,
    output logic     act_fire_o,
    output logic     load_busy_o,
    output logic     load_done_o
);

    localparam int LAST  = `SA_PE_SIZE - 1;
    localparam int CNT_W = (`SA_PE_SIZE > 1) ? $clog2(`SA_PE_SIZE) : 1;

    sa_pkg::load_state_e state;
    logic [CNT_W-1:0]    pop_cnt;
    logic                load_accept;
    logic                weights_ready;

    assign load_accept = (state == sa_pkg::IDLE) && load_start_i && !bus.any_empty;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state         <= sa_pkg::IDLE;
            pop_cnt       <= '0;
            weights_ready <= 1'b0;
        end else begin
            case (state)
                sa_pkg::IDLE: begin
                    pop_cnt <= '0;
                    if (load_accept) begin
                        state         <= sa_pkg::POP;
                        weights_ready <= 1'b0;
                    end
                end
                sa_pkg::POP: begin
                    pop_cnt <= pop_cnt + 1'b1;
                    if (pop_cnt == CNT_W'(LAST)) begin
                        state <= sa_pkg::DRAIN;
                    end
                end
                sa_pkg::DRAIN: begin
                    // Last column has taken its final word.
                    if (!bus.col_en[LAST]) begin
                        state         <= sa_pkg::IDLE;
                        weights_ready <= 1'b1;
                    end
                end
                default: state <= sa_pkg::IDLE;
            endcase
        end
    end

    assign bus.rden = (state == sa_pkg::POP);

    // Busy spans the pop phase plus the skew of the last column.
    assign load_busy_o = (state == sa_pkg::POP) ||
                         ((state == sa_pkg::DRAIN) && bus.col_en[LAST]);
    assign load_done_o = (state == sa_pkg::DRAIN) && !bus.col_en[LAST];

    // Weights are stable from the done cycle on.
    assign act_fire_o = act_valid_i && (weights_ready || load_done_o) &&
                        !load_busy_o && !load_accept;

endmodule

// File: source/pe_array.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

module pe_array (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic          [`SA_PE_SIZE-1:0] col_en_i,
    input  sa_pkg::data_t [`SA_PE_SIZE-1:0] w_data_i,
    input  logic                            act_fire_i,
    input  sa_pkg::data_t [`SA_PE_SIZE-1:0] act_data_i,
    output logic                            res_valid_o,
    output sa_pkg::acc_t  [`SA_PE_SIZE-1:0] res_data_o
);

    localparam int N = `SA_PE_SIZE;

    // Row 0 of w_link and p_link feeds the top edge of the grid.
    sa_pkg::data_t          w_link [N+1][N];
    sa_pkg::data_t          a_link [N][N];
    sa_pkg::acc_t           p_link [N+1][N];
    sa_pkg::data_t [N-1:0]  act_in;
    logic          [2*N-1:0] vld_q;

    // Bubbles carry zero so idle columns sum to zero.
    assign act_in = act_fire_i ? act_data_i : '0;

    for (genvar r = 0; r < N; r++) begin : g_skew
        if (r == 0) begin : g_direct
            assign a_link[r][0] = act_in[r];
        end else begin : g_dly
            sa_pkg::data_t dly_q [r];

            always_ff @(posedge clk) begin
                dly_q[0] <= act_in[r];
                for (int k = 1; k < r; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end

            assign a_link[r][0] = dly_q[r-1];
        end
    end

    for (genvar c = 0; c < N; c++) begin : g_edge
        assign w_link[0][c] = w_data_i[c];
        assign p_link[0][c] = '0;
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            sa_pkg::acc_t prod;

            assign prod = a_link[r][c] * w_link[r+1][c];

            always_ff @(posedge clk) begin
                // Weights shift down one row while the column loads.
                if (col_en_i[c]) begin
                    w_link[r+1][c] <= w_link[r][c];
                end
                p_link[r+1][c] <= p_link[r][c] + prod;
            end

            // The last column passes its activation nowhere.
            if (c < N - 1) begin : g_pass
                always_ff @(posedge clk) begin
                    a_link[r][c+1] <= a_link[r][c];
                end
            end
        end
    end

    // Column c leaves the grid c cycles late, so it waits N-1-c more.
    for (genvar c = 0; c < N; c++) begin : g_deskew
        sa_pkg::acc_t dsk_q [N-c];

        always_ff @(posedge clk) begin
            dsk_q[0] <= p_link[N][c];
            for (int k = 1; k < N - c; k++) begin
                dsk_q[k] <= dsk_q[k-1];
            end
        end

        assign res_data_o[c] = dsk_q[N-c-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[2*N-2:0], act_fire_i};
        end
    end

    assign res_valid_o = vld_q[2*N-1];

endmodule

// File: source/systolic_top.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

module systolic_top (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            wr_en_i,
    input  sa_pkg::data_t [`SA_PE_SIZE-1:0] wr_data_i,
    output logic                            buf_full_o,
    input  logic                            load_start_i,
    output logic                            load_busy_o,
    output logic                            load_done_o,
    input  logic                            act_valid_i,
    input  sa_pkg::data_t [`SA_PE_SIZE-1:0] act_data_i,
    output logic                            res_valid_o,
    output sa_pkg::acc_t  [`SA_PE_SIZE-1:0] res_data_o
);

    buf_ctrl_if bus_if ();

    sa_pkg::data_t [`SA_PE_SIZE-1:0] w_data;
    logic                            act_fire;

    weight_buffer i_weight_buffer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (wr_data_i),
        .rd_data_o  (w_data),
        .buf_full_o (buf_full_o),
        .bus        (bus_if.wbuf)
    );

    sa_ctrl i_sa_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_start_i (load_start_i),
        .act_valid_i  (act_valid_i),
        .bus          (bus_if.ctrl),
        .act_fire_o   (act_fire),
        .load_busy_o  (load_busy_o),
        .load_done_o  (load_done_o)
    );

    pe_array i_pe_array (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .col_en_i    (bus_if.col_en),
        .w_data_i    (w_data),
        .act_fire_i  (act_fire),
        .act_data_i  (act_data_i),
        .res_valid_o (res_valid_o),
        .res_data_o  (res_data_o)
    );

endmodule

// File: tests/systolic_chk.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

module systolic_chk (
    input  logic clk,
    input  logic rst_n_i,
    input  logic load_start_i,
    input  logic load_busy_o,
    input  logic load_done_o,
    input  logic act_valid_i,
    input  logic res_valid_o,
    input  logic buf_full_o
);

    localparam int N        = `SA_PE_SIZE;
    localparam int LAT      = 2 * N;
    localparam int BUSY_LEN = 2 * N - 1;

    int unsigned fail_cnt;
    logic        w_rdy;
    logic        act_taken;

    initial fail_cnt = 0;

    // Weights are usable from the done pulse until the next load begins.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            w_rdy <= 1'b0;
        end else if (load_done_o) begin
            w_rdy <= 1'b1;
        end else if (load_busy_o) begin
            w_rdy <= 1'b0;
        end
    end

    assign act_taken = act_valid_i && (w_rdy || load_done_o) && !load_busy_o;

    a_reset_outputs: assert property (@(posedge clk)
        !rst_n_i |=> !load_busy_o && !load_done_o && !res_valid_o && !buf_full_o)
        else begin
            $error("outputs not cleared by reset");
            fail_cnt++;
        end

    a_busy_length: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(load_busy_o) |->
            load_busy_o [*BUSY_LEN] ##1 (!load_busy_o && load_done_o) ##1 !load_done_o)
        else begin
            $error("load_busy_o length or load_done_o pulse wrong");
            fail_cnt++;
        end

    a_busy_needs_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(load_busy_o) |-> $past(load_start_i))
        else begin
            $error("load_busy_o rose without load_start_i");
            fail_cnt++;
        end

    a_res_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        act_taken |-> ##LAT res_valid_o)
        else begin
            $error("res_valid_o missing after an accepted activation");
            fail_cnt++;
        end

    a_no_stray_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o |-> $past(act_taken, LAT))
        else begin
            $error("res_valid_o without an accepted activation");
            fail_cnt++;
        end

endmodule

// File: tests/tb_systolic_top.sv
`timescale 1ns/1ps
`include "sa_macros.svh"

module tb_systolic_top;

    localparam int N          = `SA_PE_SIZE;
    localparam int W          = `SA_DATA_W;
    localparam int LAT        = 2 * N;
    localparam int MATVEC_CNT = 6;
    localparam int BURST_CNT  = 2 * N + 2;

    // Cycle budget of each test in order, plus margin.
    localparam int TIMEOUT_CYCLES = (4 + 2) + (4 + 2 * LAT) + (N + 2) + (2 * N + 2)
                                  + (3 * MATVEC_CNT + 2 * LAT)
                                  + (2 * BURST_CNT + N + 2 * N + 2 + 4 * LAT) + 100;

    typedef sa_pkg::data_t [N-1:0] row_t;
    typedef sa_pkg::acc_t  [N-1:0] res_t;

    logic clk;
    logic rst_n_i;
    logic wr_en_i;
    row_t wr_data_i;
    logic buf_full_o;
    logic load_start_i;
    logic load_busy_o;
    logic load_done_o;
    logic act_valid_i;
    row_t act_data_i;
    logic res_valid_o;
    res_t res_data_o;

    logic [15:0] lfsr_q;
    int          w_mdl [N][N];
    row_t        buf_mdl [$];
    res_t        exp_q [$];
    int          err_cnt;
    int          err_base;
    int          tests_passed;
    int          tests_failed;
    int          cycle_cnt;

    systolic_top i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_en_i      (wr_en_i),
        .wr_data_i    (wr_data_i),
        .buf_full_o   (buf_full_o),
        .load_start_i (load_start_i),
        .load_busy_o  (load_busy_o),
        .load_done_o  (load_done_o),
        .act_valid_i  (act_valid_i),
        .act_data_i   (act_data_i),
        .res_valid_o  (res_valid_o),
        .res_data_o   (res_data_o)
    );

    bind systolic_top systolic_chk i_chk (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_start_i (load_start_i),
        .load_busy_o  (load_busy_o),
        .load_done_o  (load_done_o),
        .act_valid_i  (act_valid_i),
        .res_valid_o  (res_valid_o),
        .buf_full_o   (buf_full_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic row_t rand_row();
        logic [N*W-1:0] bits;
        bits = '0;
        for (int i = 0; i < N * W; i++) begin
            bits = {bits[N*W-2:0], lfsr_bit()};
        end
        return row_t'(bits);
    endfunction

    function automatic res_t matvec(input row_t act);
        res_t res;
        int   sum;
        for (int c = 0; c < N; c++) begin
            sum = 0;
            for (int r = 0; r < N; r++) begin
                sum += int'(act[r]) * w_mdl[r][c];
            end
            res[c] = sa_pkg::acc_t'(sum);
        end
        return res;
    endfunction

    function automatic int total_errors();
        return err_cnt + int'(i_dut.i_chk.fail_cnt);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("error %s: expected %h, got %h", name, exp_v, got_v);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs     = total_errors() - err_base;
        err_base = total_errors();
        if (errs == 0) begin
            tests_passed++;
            $display("%-16s passed", name);
        end else begin
            tests_failed++;
            $display("%-16s failed with %0d errors", name, errs);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_row();
        row_t row;
        row       = rand_row();
        wr_en_i   = 1'b1;
        wr_data_i = row;
        // A full lane drops the write.
        if (buf_mdl.size() < N) begin
            buf_mdl.push_back(row);
        end
        idle(1);
        wr_en_i = 1'b0;
    endtask

    task automatic send_vector(input bit accepted);
        row_t act;
        act         = rand_row();
        act_valid_i = 1'b1;
        act_data_i  = act;
        if (accepted) begin
            exp_q.push_back(matvec(act));
        end
        idle(1);
        act_valid_i = 1'b0;
    endtask

    task automatic run_load(input bit act_while_busy);
        int   busy_cycles;
        int   waited;
        bit   done_seen;
        row_t row;
        busy_cycles  = 0;
        waited       = 0;
        done_seen    = 1'b0;
        load_start_i = 1'b1;
        idle(1);
        load_start_i = 1'b0;
        while (!done_seen && waited < 4 * N) begin
            if (load_busy_o) begin
                busy_cycles++;
            end
            done_seen   = load_done_o;
            act_valid_i = act_while_busy && load_busy_o;
            act_data_i  = rand_row();
            idle(1);
            waited++;
        end
        act_valid_i = 1'b0;
        assert (done_seen) else report_problem("load_done_o never pulsed after a load");
        assert (busy_cycles == 2 * N - 1)
            else report_mismatch("load_busy_o length", 2 * N - 1, busy_cycles);
        assert (load_done_o === 1'b0) else report_mismatch("load_done_o", 0, load_done_o);
        // Word k of each lane lands in row N-1-k.
        for (int k = 0; k < N; k++) begin
            row = buf_mdl.pop_front();
            for (int c = 0; c < N; c++) begin
                w_mdl[N-1-k][c] = int'(row[c]);
            end
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 2 * LAT) begin
            idle(1);
            waited++;
        end
        assert (exp_q.size() == 0)
            else report_problem($sformatf("%0d expected results never appeared", exp_q.size()));
        idle(2);
    endtask

    always @(negedge clk) begin
        res_t exp_v;
        if (rst_n_i === 1'b1 && res_valid_o === 1'b1) begin
            assert (exp_q.size() != 0)
                else report_problem("res_valid_o rose with no accepted activation pending");
            if (exp_q.size() != 0) begin
                exp_v = exp_q.pop_front();
                for (int c = 0; c < N; c++) begin
                    assert (res_data_o[c] === exp_v[c])
                        else report_mismatch($sformatf("res_data_o[%0d]", c),
                                             exp_v[c], res_data_o[c]);
                end
            end
        end
    end

    initial begin
        lfsr_q       = 16'd97;
        err_cnt      = 0;
        err_base     = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        rst_n_i      = 1'b0;
        wr_en_i      = 1'b0;
        wr_data_i    = '0;
        load_start_i = 1'b0;
        act_valid_i  = 1'b0;
        act_data_i   = '0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w_mdl[r][c] = 0;
            end
        end

        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        assert (load_busy_o === 1'b0) else report_mismatch("load_busy_o", 0, load_busy_o);
        assert (load_done_o === 1'b0) else report_mismatch("load_done_o", 0, load_done_o);
        assert (res_valid_o === 1'b0) else report_mismatch("res_valid_o", 0, res_valid_o);
        assert (buf_full_o === 1'b0) else report_mismatch("buf_full_o", 0, buf_full_o);
        finish_test("reset");

        // No weights yet and every lane is empty.
        for (int i = 0; i < 4; i++) begin
            send_vector(1'b0);
        end
        load_start_i = 1'b1;
        idle(1);
        load_start_i = 1'b0;
        repeat (LAT + 2) begin
            assert (load_busy_o === 1'b0)
                else report_problem("load_busy_o rose for a load with empty lanes");
            idle(1);
        end
        finish_test("idle_gating");

        for (int i = 0; i < N - 1; i++) begin
            write_row();
        end
        assert (buf_full_o === 1'b0) else report_mismatch("buf_full_o", 0, buf_full_o);
        write_row();
        assert (buf_full_o === 1'b1) else report_mismatch("buf_full_o", 1, buf_full_o);
        write_row();
        assert (buf_full_o === 1'b1) else report_mismatch("buf_full_o", 1, buf_full_o);
        finish_test("fill_full");

        run_load(1'b0);
        assert (buf_full_o === 1'b0) else report_mismatch("buf_full_o", 0, buf_full_o);
        finish_test("load_timing");

        repeat (MATVEC_CNT) begin
            send_vector(1'b1);
            idle(2);
        end
        drain_results();
        finish_test("matvec");

        repeat (BURST_CNT) begin
            send_vector(1'b1);
        end
        drain_results();
        repeat (N) begin
            write_row();
        end
        run_load(1'b1);
        repeat (BURST_CNT) begin
            send_vector(1'b1);
        end
        drain_results();
        finish_test("pipeline_reload");

        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+source
source/sa_pkg.sv
source/buf_ctrl_if.sv
source/lane_fifo.sv
source/weight_buffer.sv
source/sa_ctrl.sv
source/pe_array.sv
source/systolic_top.sv
tests/systolic_chk.sv
tests/tb_systolic_top.sv

// File: Bender.yml
package:
  name: systolic_array

sources:
  - include_dirs:
      - source
    files:
      - source/sa_pkg.sv
      - source/buf_ctrl_if.sv
      - source/lane_fifo.sv
      - source/weight_buffer.sv
      - source/sa_ctrl.sv
      - source/pe_array.sv
      - source/systolic_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/systolic_chk.sv
      - tests/tb_systolic_top.sv
